//--- Makefile
VERILATOR ?= verilator
TOP ?= core_tb
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing
FAIL_MSG ?= Simulation finished: FAIL
PASS_MSG ?= Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no verdict found in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
hw/core_pkg.sv
hw/core_decode.sv
hw/core_execute.sv
hw/core_result.sv
hw/core_top.sv
test/tb_clock.sv
test/core_checker.sv
test/core_tb.sv

//--- hw/core_decode.sv
`timescale 1ns/1ps
`default_nettype none

module core_decode (
    input wire clk5,
    input wire reset,
    input wire [core_pkg::xlen-1:0] data_in,
    input wire ready,
    input wire memory_op,
    input wire retire_halt,
    output core_pkg::stage_t stage,
    output core_pkg::decoded_t decoded
);

    logic [core_pkg::xlen-1:0] instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic alt;
    logic [core_pkg::xlen-1:0] imm_i;
    logic [core_pkg::xlen-1:0] imm_s;
    logic [core_pkg::xlen-1:0] imm_b;
    logic [core_pkg::xlen-1:0] imm_u;
    logic [core_pkg::xlen-1:0] imm_j;

    function automatic core_pkg::alu_op_t alu_op_f(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'd0: alu_op_f = sub_sra ? core_pkg::op_sub : core_pkg::op_add;
            3'd1: alu_op_f = core_pkg::op_sll;
            3'd2: alu_op_f = core_pkg::op_slt;
            3'd3: alu_op_f = core_pkg::op_sltu;
            3'd4: alu_op_f = core_pkg::op_xor;
            3'd5: alu_op_f = sub_sra ? core_pkg::op_sra : core_pkg::op_srl;
            3'd6: alu_op_f = core_pkg::op_or;
            default: alu_op_f = core_pkg::op_and;
        endcase
    endfunction

    always_ff @(posedge clk5) begin
        if (!reset) begin
            stage <= core_pkg::st_fetch;
        end else begin
            case (stage)
                core_pkg::st_fetch: begin
                    if (ready) begin
                        stage <= core_pkg::st_decode;
                    end
                end
                core_pkg::st_decode: stage <= core_pkg::st_execute;
                core_pkg::st_execute: stage <= core_pkg::st_result;
                core_pkg::st_result: begin
                    if (retire_halt) begin
                        stage <= core_pkg::st_halt;
                    end else if (!memory_op || ready) begin
                        stage <= core_pkg::st_fetch;
                    end
                end
                default: stage <= core_pkg::st_halt;   // halt is final.
            endcase
        end
    end

    always_ff @(posedge clk5) begin
        if (stage == core_pkg::st_fetch && ready) begin
            instr <= data_in;
        end
    end

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    // funct7 bit 5 picks sub/sra; for immediates only on shifts right.
    assign alt = funct7[5] && (opcode == 7'b0110011 || funct3 == 3'd5);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        decoded.kind = core_pkg::k_illegal;
        decoded.alu_op = alu_op_f(funct3, alt);
        decoded.funct3 = funct3;
        decoded.rs1 = instr[19:15];
        decoded.rs2 = instr[24:20];
        decoded.rd = instr[11:7];
        decoded.imm = imm_i;
        case (opcode)
            7'b0110011: begin
                if (funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'd0 || funct3 == 3'd5))) begin
                    decoded.kind = core_pkg::k_alu;
                end
            end
            7'b0010011: begin
                if ((funct3 != 3'd1 && funct3 != 3'd5) || funct7 == 7'b0000000 ||
                    (funct3 == 3'd5 && funct7 == 7'b0100000)) begin
                    decoded.kind = core_pkg::k_alu_imm;
                end
            end
            7'b0110111: begin
                decoded.kind = core_pkg::k_lui;
                decoded.imm = imm_u;
            end
            7'b0010111: begin
                decoded.kind = core_pkg::k_auipc;
                decoded.imm = imm_u;
            end
            7'b0000011: begin
                if (funct3 != 3'd3 && funct3 != 3'd6 && funct3 != 3'd7) begin
                    decoded.kind = core_pkg::k_load;
                end
            end
            7'b0100011: begin
                decoded.imm = imm_s;
                if (funct3 == 3'd0 || funct3 == 3'd1 || funct3 == 3'd2) begin
                    decoded.kind = core_pkg::k_store;
                end
            end
            7'b1100011: begin
                decoded.imm = imm_b;
                if (funct3 != 3'd2 && funct3 != 3'd3) begin
                    decoded.kind = core_pkg::k_branch;
                end
            end
            7'b1101111: begin
                decoded.kind = core_pkg::k_jal;
                decoded.imm = imm_j;
            end
            7'b1100111: begin
                if (funct3 == 3'd0) begin
                    decoded.kind = core_pkg::k_jalr;
                end
            end
            7'b1110011: begin
                // only ecall and ebreak, no csrs.
                if (instr == 32'h0000_0073 || instr == 32'h0010_0073) begin
                    decoded.kind = core_pkg::k_system;
                end
            end
            default: decoded.kind = core_pkg::k_illegal;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/core_execute.sv
`timescale 1ns/1ps
`default_nettype none

module core_execute (
    input wire core_pkg::decoded_t decoded,
    input wire [core_pkg::xlen-1:0] rs1_value,
    input wire [core_pkg::xlen-1:0] rs2_value,
    input wire [core_pkg::xlen-1:0] pc,
    output core_pkg::exec_t exec
);

    logic [core_pkg::xlen-1:0] operand_b;
    logic [core_pkg::xlen-1:0] alu_result;
    logic [core_pkg::xlen-1:0] mem_addr;
    logic [core_pkg::xlen-1:0] pc_target;
    logic [core_pkg::xlen-1:0] pc_plus4;
    logic [4:0] shamt;
    logic taken;
    logic [3:0] lanes;

    assign operand_b = decoded.kind == core_pkg::k_alu ? rs2_value : decoded.imm;
    assign shamt = operand_b[4:0];
    assign mem_addr = rs1_value + decoded.imm;   // also the jalr target.
    assign pc_target = pc + decoded.imm;
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (decoded.alu_op)
            core_pkg::op_add: alu_result = rs1_value + operand_b;
            core_pkg::op_sub: alu_result = rs1_value - operand_b;
            core_pkg::op_sll: alu_result = rs1_value << shamt;
            core_pkg::op_slt: alu_result = {31'd0, $signed(rs1_value) < $signed(operand_b)};
            core_pkg::op_sltu: alu_result = {31'd0, rs1_value < operand_b};
            core_pkg::op_xor: alu_result = rs1_value ^ operand_b;
            core_pkg::op_srl: alu_result = rs1_value >> shamt;
            core_pkg::op_sra: alu_result = $unsigned($signed(rs1_value) >>> shamt);
            core_pkg::op_or: alu_result = rs1_value | operand_b;
            default: alu_result = rs1_value & operand_b;
        endcase
    end

    always_comb begin
        case (decoded.funct3)
            3'd0: taken = rs1_value == rs2_value;
            3'd1: taken = rs1_value != rs2_value;
            3'd4: taken = $signed(rs1_value) < $signed(rs2_value);
            3'd5: taken = $signed(rs1_value) >= $signed(rs2_value);
            3'd6: taken = rs1_value < rs2_value;
            default: taken = rs1_value >= rs2_value;
        endcase
    end

    // lanes touched by the access; an empty mask marks it misaligned.
    always_comb begin
        case (decoded.funct3[1:0])
            2'd0: lanes = 4'b0001 << mem_addr[1:0];
            2'd1: lanes = mem_addr[0] ? 4'b0000 : 4'b0011 << mem_addr[1:0];
            2'd2: lanes = mem_addr[1:0] == 2'd0 ? 4'b1111 : 4'b0000;
            default: lanes = 4'b0000;
        endcase
    end

    always_comb begin
        exec.value = alu_result;
        exec.mem_addr = mem_addr;
        exec.next_pc = pc_plus4;
        exec.lanes = lanes;
        exec.reg_write = decoded.rd != '0;      // x0 is never written.
        case (decoded.kind)
            core_pkg::k_lui: exec.value = decoded.imm;
            core_pkg::k_auipc: exec.value = pc_target;
            core_pkg::k_jal: begin
                exec.value = pc_plus4;
                exec.next_pc = pc_target;
            end
            core_pkg::k_jalr: begin
                exec.value = pc_plus4;
                exec.next_pc = {mem_addr[core_pkg::xlen-1:1], 1'b0};
            end
            core_pkg::k_branch: begin
                exec.reg_write = 1'b0;
                if (taken) begin
                    exec.next_pc = pc_target;
                end
            end
            core_pkg::k_store, core_pkg::k_system, core_pkg::k_illegal: begin
                exec.reg_write = 1'b0;
            end
            default: exec.value = alu_result;   // alu, alu_imm, load.
        endcase
    end

endmodule

`default_nettype wire

//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen = 32;
    localparam int reg_count = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_result,
        st_halt
    } stage_t;

    typedef enum logic [3:0] {
        k_alu,
        k_alu_imm,
        k_lui,
        k_auipc,
        k_load,
        k_store,
        k_branch,
        k_jal,
        k_jalr,
        k_system,
        k_illegal
    } instr_kind_t;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_sll,
        op_slt,
        op_sltu,
        op_xor,
        op_srl,
        op_sra,
        op_or,
        op_and
    } alu_op_t;

    typedef struct packed {
        instr_kind_t kind;
        alu_op_t alu_op;
        logic [2:0] funct3;              // access width or branch condition.
        logic [$clog2(reg_count)-1:0] rs1;
        logic [$clog2(reg_count)-1:0] rs2;
        logic [$clog2(reg_count)-1:0] rd;
        logic [xlen-1:0] imm;            // already sign extended.
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0] value;          // alu result, upper imm or link.
        logic [xlen-1:0] mem_addr;
        logic [xlen-1:0] next_pc;
        logic [3:0] lanes;               // zero when misaligned.
        logic reg_write;
    } exec_t;

endpackage

`default_nettype wire

//--- hw/core_result.sv
`timescale 1ns/1ps
`default_nettype none

module core_result (
    input wire clk5,
    input wire reset,
    input wire core_pkg::stage_t stage,
    input wire core_pkg::decoded_t decoded,
    input wire core_pkg::exec_t exec,
    input wire [core_pkg::xlen-1:0] data_in,
    input wire ready,
    output logic [core_pkg::xlen-1:0] address,
    output logic [core_pkg::xlen-1:0] data_out,
    output logic rd,
    output logic [3:0] wr,
    output logic [core_pkg::xlen-1:0] rs1_value,
    output logic [core_pkg::xlen-1:0] rs2_value,
    output logic [core_pkg::xlen-1:0] pc,
    output logic memory_op,
    output logic retire_halt,
    output logic halted,
    output logic fault
);

    logic [core_pkg::xlen-1:0] regs [core_pkg::reg_count];
    logic is_load;
    logic is_store;
    logic misaligned;
    logic in_result;
    logic retire;
    logic fault_now;
    logic [core_pkg::xlen-1:0] load_shifted;
    logic [core_pkg::xlen-1:0] load_value;
    logic [core_pkg::xlen-1:0] write_value;

    assign is_load = decoded.kind == core_pkg::k_load;
    assign is_store = decoded.kind == core_pkg::k_store;
    assign misaligned = (is_load || is_store) && exec.lanes == 4'b0000;
    assign memory_op = (is_load || is_store) && !misaligned;
    assign in_result = stage == core_pkg::st_result;
    assign retire = in_result && (!memory_op || ready);   // waits for ready on access.

    assign fault_now = decoded.kind == core_pkg::k_illegal || pc[1:0] != 2'b00 || misaligned;
    assign retire_halt = retire && (decoded.kind == core_pkg::k_system || fault_now);

    assign rs1_value = decoded.rs1 == '0 ? '0 : regs[decoded.rs1];
    assign rs2_value = decoded.rs2 == '0 ? '0 : regs[decoded.rs2];

    // bus is held stable until ready.
    assign address = stage == core_pkg::st_fetch ? pc : exec.mem_addr;
    assign rd = stage == core_pkg::st_fetch || (in_result && is_load && memory_op);
    assign wr = (in_result && is_store && memory_op) ? exec.lanes : 4'b0000;
    assign data_out = rs2_value << {exec.mem_addr[1:0], 3'b000};

    assign load_shifted = data_in >> {exec.mem_addr[1:0], 3'b000};

    always_comb begin
        case (decoded.funct3)
            3'd0: load_value = {{24{load_shifted[7]}}, load_shifted[7:0]};
            3'd1: load_value = {{16{load_shifted[15]}}, load_shifted[15:0]};
            3'd4: load_value = {24'h00_0000, load_shifted[7:0]};
            3'd5: load_value = {16'h0000, load_shifted[15:0]};
            default: load_value = load_shifted;
        endcase
    end

    assign write_value = is_load ? load_value : exec.value;

    always_ff @(posedge clk5) begin
        if (retire && !fault_now && exec.reg_write) begin
            regs[decoded.rd] <= write_value;
        end
    end

    always_ff @(posedge clk5) begin
        if (!reset) begin
            pc <= core_pkg::reset_pc;
            halted <= 1'b0;
            fault <= 1'b0;
        end else if (retire) begin
            if (retire_halt) begin
                halted <= 1'b1;
            end
            if (fault_now) begin
                fault <= 1'b1;           // sticky, pc stays on the culprit.
            end else begin
                pc <= exec.next_pc;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input wire clk5,
    input wire reset,
    output wire [core_pkg::xlen-1:0] address,
    input wire [core_pkg::xlen-1:0] data_in,
    output wire [core_pkg::xlen-1:0] data_out,
    output wire rd,
    output wire [3:0] wr,
    input wire ready,
    output wire halted,
    output wire fault
);

    core_pkg::stage_t stage;
    core_pkg::decoded_t decoded;
    core_pkg::exec_t exec;
    logic [core_pkg::xlen-1:0] rs1_value;
    logic [core_pkg::xlen-1:0] rs2_value;
    logic [core_pkg::xlen-1:0] pc;
    logic memory_op;
    logic retire_halt;

    core_decode i_decode (
        .clk5(clk5),
        .reset(reset),
        .data_in(data_in),
        .ready(ready),
        .memory_op(memory_op),
        .retire_halt(retire_halt),
        .stage(stage),
        .decoded(decoded)
    );

    core_execute i_execute (
        .decoded(decoded),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .pc(pc),
        .exec(exec)
    );

    core_result i_result (
        .clk5(clk5),
        .reset(reset),
        .stage(stage),
        .decoded(decoded),
        .exec(exec),
        .data_in(data_in),
        .ready(ready),
        .address(address),
        .data_out(data_out),
        .rd(rd),
        .wr(wr),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .pc(pc),
        .memory_op(memory_op),
        .retire_halt(retire_halt),
        .halted(halted),
        .fault(fault)
    );

endmodule

`default_nettype wire

//--- test/core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_checker (
    input wire clk5,
    input wire reset,
    input wire [31:0] address,
    input wire [31:0] data_out,
    input wire rd,
    input wire [3:0] wr,
    input wire ready,
    input wire halted,
    input wire fault
);

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0] lanes;
        logic [31:0] data;       // only the enabled lanes count.
    } store_t;

    store_t pending[$];
    int errors = 0;
    int stores_seen = 0;

    function automatic logic [31:0] lane_mask(input logic [3:0] lanes);
        return {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
    endfunction

    task automatic expect_store(input logic [31:0] addr, input logic [3:0] lanes,
                                input logic [31:0] data);
        store_t item;
        item.addr = addr;
        item.lanes = lanes;
        item.data = data & lane_mask(lanes);
        pending.push_back(item);
    endtask

    // a store completes on the next rising edge when ready is high.
    always @(negedge clk5) begin
        store_t want;
        if (reset && rd && wr != 4'b0000) begin
            errors++;
            $display("read and write requested together at 0x%h", address);
        end
        if (reset && ready && wr != 4'b0000) begin
            stores_seen++;
            if (pending.size() == 0) begin
                errors++;
                $display("store to 0x%h arrived when no store was expected", address);
            end else begin
                want = pending.pop_front();
                if (address !== want.addr) begin
                    errors++;
                    $display("Fail: address = 0x%h, expected 0x%h", address, want.addr);
                end
                if (wr !== want.lanes) begin
                    errors++;
                    $display("Fail: wr = 0x%h, expected 0x%h", wr, want.lanes);
                end
                if ((data_out & lane_mask(want.lanes)) !== want.data) begin
                    errors++;
                    $display("Fail: data_out = 0x%h, expected 0x%h at 0x%h",
                             data_out & lane_mask(want.lanes), want.data, want.addr);
                end
            end
        end
    end

    // fetch starts right out of reset.
    task automatic check_start();
        if (rd !== 1'b1) begin
            errors++;
            $display("Fail: rd = 0x%h, expected 0x1", rd);
        end
        if (wr !== 4'b0000) begin
            errors++;
            $display("Fail: wr = 0x%h, expected 0x0", wr);
        end
        if (halted !== 1'b0) begin
            errors++;
            $display("Fail: halted = 0x%h, expected 0x0", halted);
        end
        if (fault !== 1'b0) begin
            errors++;
            $display("Fail: fault = 0x%h, expected 0x0", fault);
        end
    endtask

    task automatic check_end(input logic want_fault);
        if (halted !== 1'b1) begin
            errors++;
            $display("Fail: halted = 0x%h, expected 0x1", halted);
        end
        if (fault !== want_fault) begin
            errors++;
            $display("Fail: fault = 0x%h, expected 0x%h", fault, want_fault);
        end
        if (rd !== 1'b0) begin
            errors++;
            $display("Fail: rd = 0x%h, expected 0x0", rd);
        end
        if (pending.size() != 0) begin
            errors++;
            $display("%0d expected stores never appeared on the bus", pending.size());
            pending.delete();
        end
    endtask

endmodule

`default_nettype wire

//--- test/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] slot;       // word after the instruction under test.
        logic [31:0] st_addr;
        logic [3:0] st_lanes;    // nonzero when the instruction itself stores.
        logic [31:0] st_data;
        logic [31:0] result;     // expected x3, stored by the closing sw.
    } row_t;

    logic clk5;
    logic reset;
    logic restart;
    logic ready;
    logic stall_mode;
    logic timed_out;
    logic [31:0] rng;
    logic [31:0] address;
    logic [31:0] data_in;
    logic [31:0] data_out;
    logic rd;
    logic [3:0] wr;
    logic halted;
    logic fault;
    logic [31:0] mem [1024];
    row_t rows[$];
    int limit;

    tb_clock i_clock (.restart(restart), .clk5(clk5), .reset(reset));

    core_top i_dut (
        .clk5(clk5),
        .reset(reset),
        .address(address),
        .data_in(data_in),
        .data_out(data_out),
        .rd(rd),
        .wr(wr),
        .ready(ready),
        .halted(halted),
        .fault(fault)
    );

    core_checker i_checker (
        .clk5(clk5),
        .reset(reset),
        .address(address),
        .data_out(data_out),
        .rd(rd),
        .wr(wr),
        .ready(ready),
        .halted(halted),
        .fault(fault)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    // register ops always x3 = x1 op x2.
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
    endfunction

    function automatic logic [31:0] alu_imm(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3);
        return i_type(imm, rs1, f3, 5'd3, 7'b0010011);
    endfunction

    function automatic logic [31:0] load(input logic [2:0] f3, input logic [11:0] addr);
        return i_type(addr, 5'd0, f3, 5'd3, 7'b0000011);
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
    endfunction

    // branch over the slot word, straight to the sw.
    function automatic logic [31:0] branch_skip(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2);
        return {1'b0, 6'd0, rs2, rs1, f3, 4'b0100, 1'b0, 7'b1100011};
    endfunction

    task automatic add_store_row(input logic [31:0] instr, input logic [31:0] slot,
                                 input logic [31:0] st_addr, input logic [3:0] st_lanes,
                                 input logic [31:0] st_data, input logic [31:0] result);
        row_t row;
        row.instr = instr;
        row.slot = slot;
        row.st_addr = st_addr;
        row.st_lanes = st_lanes;
        row.st_data = st_data;
        row.result = result;
        rows.push_back(row);
    endtask

    task automatic add_row(input logic [31:0] instr, input logic [31:0] slot,
                           input logic [31:0] result);
        add_store_row(instr, slot, 32'h0, 4'h0, 32'h0, result);
    endtask

    task automatic build_table();
        logic [31:0] nop;
        logic [31:0] skipped;
        logic [31:0] reload;
        nop = 32'h0000_0013;
        skipped = alu_imm(12'h0BB, 5'd0, 3'd0);
        reload = load(3'd2, 12'h500);
        // x1 = -20, x2 = 3; entry i starts at 0x10 + 16*i, marker x3 = 0xaa.
        add_row(r_type(7'h00, 3'd0), nop, 32'hFFFF_FFEF);
        add_row(r_type(7'h20, 3'd0), nop, 32'hFFFF_FFE9);      // sub.
        add_row(r_type(7'h00, 3'd1), nop, 32'hFFFF_FF60);
        add_row(r_type(7'h00, 3'd2), nop, 32'h0000_0001);      // slt, signed.
        add_row(r_type(7'h00, 3'd3), nop, 32'h0000_0000);
        add_row(r_type(7'h00, 3'd4), nop, 32'hFFFF_FFEF);
        add_row(r_type(7'h00, 3'd5), nop, 32'h1FFF_FFFD);
        add_row(r_type(7'h20, 3'd5), nop, 32'hFFFF_FFFD);      // sra keeps the sign.
        add_row(r_type(7'h00, 3'd6), nop, 32'hFFFF_FFEF);
        add_row(r_type(7'h00, 3'd7), nop, 32'h0000_0000);
        add_row(alu_imm(12'h064, 5'd1, 3'd0), nop, 32'h0000_0050);
        add_row(alu_imm(12'hFED, 5'd1, 3'd2), nop, 32'h0000_0001);
        add_row(alu_imm(12'hFFF, 5'd2, 3'd3), nop, 32'h0000_0001);
        add_row(alu_imm(12'hFFF, 5'd1, 3'd4), nop, 32'h0000_0013);
        add_row(alu_imm(12'h070, 5'd2, 3'd6), nop, 32'h0000_0073);
        add_row(alu_imm(12'h0FF, 5'd1, 3'd7), nop, 32'h0000_00EC);
        add_row(alu_imm(12'h01E, 5'd2, 3'd1), nop, 32'hC000_0000);
        add_row(alu_imm(12'h01C, 5'd1, 3'd5), nop, 32'h0000_000F);
        add_row(alu_imm(12'h402, 5'd1, 3'd5), nop, 32'hFFFF_FFFB);   // srai.
        add_row({20'h12345, 5'd3, 7'b0110111}, nop, 32'h1234_5000);
        add_row({20'h00001, 5'd3, 7'b0010111}, nop, 32'h0000_1154);  // auipc at 0x154.
        add_row({1'b0, 10'd4, 1'b0, 8'd0, 5'd3, 7'b1101111}, skipped, 32'h0000_0168);
        add_row(i_type(12'h17C, 5'd0, 3'd0, 5'd3, 7'b1100111), skipped, 32'h0000_0178);
        add_row(branch_skip(3'd0, 5'd1, 5'd2), skipped, 32'h0000_00BB);
        add_row(branch_skip(3'd0, 5'd2, 5'd2), skipped, 32'h0000_00AA);
        add_row(branch_skip(3'd1, 5'd1, 5'd2), skipped, 32'h0000_00AA);
        add_row(branch_skip(3'd1, 5'd1, 5'd1), skipped, 32'h0000_00BB);
        add_row(branch_skip(3'd4, 5'd1, 5'd2), skipped, 32'h0000_00AA);
        add_row(branch_skip(3'd4, 5'd2, 5'd1), skipped, 32'h0000_00BB);
        add_row(branch_skip(3'd5, 5'd2, 5'd1), skipped, 32'h0000_00AA);
        add_row(branch_skip(3'd5, 5'd1, 5'd2), skipped, 32'h0000_00BB);
        add_row(branch_skip(3'd6, 5'd1, 5'd2), skipped, 32'h0000_00BB);  // -20 is huge unsigned.
        add_row(branch_skip(3'd6, 5'd2, 5'd1), skipped, 32'h0000_00AA);
        add_row(branch_skip(3'd7, 5'd1, 5'd2), skipped, 32'h0000_00AA);
        add_row(branch_skip(3'd7, 5'd2, 5'd1), skipped, 32'h0000_00BB);
        add_row(load(3'd0, 12'h400), nop, 32'hFFFF_FFA1);
        add_row(load(3'd4, 12'h401), nop, 32'h0000_00F0);
        add_row(load(3'd0, 12'h402), nop, 32'h0000_0065);
        add_row(load(3'd1, 12'h402), nop, 32'hFFFF_8765);
        add_row(load(3'd5, 12'h400), nop, 32'h0000_F0A1);
        add_row(load(3'd2, 12'h400), nop, 32'h8765_F0A1);
        add_store_row(s_type(12'h501, 5'd2, 3'd0), reload, 32'h501, 4'b0010,
                      32'h0000_0300, 32'h1122_0344);
        add_store_row(s_type(12'h502, 5'd1, 3'd1), reload, 32'h502, 4'b1100,
                      32'hFFEC_0000, 32'hFFEC_0344);
        add_store_row(s_type(12'h500, 5'd1, 3'd0), reload, 32'h500, 4'b0001,
                      32'h0000_00EC, 32'hFFEC_03EC);
    endtask

    task automatic load_program(input logic illegal_word);
        logic [9:0] at;
        logic [31:0] res_addr;
        for (int i = 0; i < 1024; i++) begin
            mem[10'(i)] = 32'hBAD0_0000 ^ (i << 2);
        end
        mem[10'h100] = 32'h8765_F0A1;                  // load data at 0x400.
        mem[10'h140] = 32'h1122_3344;                  // store target at 0x500.
        if (illegal_word) begin
            mem[10'h000] = alu_imm(12'h055, 5'd0, 3'd0);
            mem[10'h001] = s_type(12'h600, 5'd3, 3'd2);
            mem[10'h002] = 32'hFFFF_FFFF;
            i_checker.expect_store(32'h600, 4'hF, 32'h0000_0055);
        end else begin
            mem[10'h000] = i_type(12'hFEC, 5'd0, 3'd0, 5'd1, 7'b0010011);
            mem[10'h001] = i_type(12'h003, 5'd0, 3'd0, 5'd2, 7'b0010011);
            mem[10'h002] = 32'h0000_0013;
            mem[10'h003] = 32'h0000_0013;
            for (int i = 0; i < rows.size(); i++) begin
                at = 10'(4 + 4 * i);
                res_addr = 32'h600 + 32'(4 * i);
                mem[at] = alu_imm(12'h0AA, 5'd0, 3'd0);
                mem[at + 10'd1] = rows[i].instr;
                mem[at + 10'd2] = rows[i].slot;
                mem[at + 10'd3] = s_type(res_addr[11:0], 5'd3, 3'd2);
                if (rows[i].st_lanes != 4'h0) begin
                    i_checker.expect_store(rows[i].st_addr, rows[i].st_lanes, rows[i].st_data);
                end
                i_checker.expect_store(res_addr, 4'hF, rows[i].result);
            end
            mem[10'(4 + 4 * rows.size())] = 32'h0010_0073;   // ebreak.
        end
    endtask

    assign data_in = rd ? mem[address[11:2]] : 32'hFFFF_FFFF;   // no data without a read.

    always @(negedge clk5) begin
        logic [31:0] mask;
        mask = {{8{wr[3]}}, {8{wr[2]}}, {8{wr[1]}}, {8{wr[0]}}};
        if (reset && ready && wr != 4'b0000) begin
            mem[address[11:2]] = (mem[address[11:2]] & ~mask) | (data_out & mask);
        end
    end

    always @(posedge clk5) begin
        #0.5;
        if (stall_mode) begin
            rng = xorshift(rng);
            ready = rng[1:0] != 2'b00;                // about one stall in four.
        end else begin
            ready = 1'b1;
        end
    end

    task automatic run_program(input logic stalls, input logic illegal_word);
        int cycles;
        load_program(illegal_word);
        stall_mode = stalls;
        @(posedge clk5);
        #0.5;
        restart = 1'b1;
        @(posedge reset);
        restart = 1'b0;
        i_checker.check_start();
        cycles = 0;
        while (halted !== 1'b1 && cycles <= limit) begin
            @(negedge clk5);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("timeout: core did not halt within %0d cycles", limit);
            timed_out = 1'b1;
        end else begin
            i_checker.check_end(illegal_word);
        end
    endtask

    initial begin
        ready = 1'b0;
        restart = 1'b0;
        stall_mode = 1'b0;
        timed_out = 1'b0;
        rng = 32'h7716;
        build_table();
        limit = rows.size() * 12 * 4;
        run_program(1'b0, 1'b0);
        if (!timed_out) begin
            run_program(1'b1, 1'b0);                  // same results under stalls.
        end
        if (!timed_out) begin
            run_program(1'b1, 1'b1);
        end
        $display("errors: %0d, stores checked: %0d, timeouts: %0d",
                 i_checker.errors, i_checker.stores_seen, timed_out);
        if (i_checker.errors == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    input wire restart,
    output logic clk5,
    output logic reset
);

    initial begin
        clk5 = 1'b0;
        forever #2 clk5 = ~clk5;       // 4 ns period.
    end

    // each restart request gives 3 cycles of reset.
    initial begin
        reset = 1'b0;
        forever begin
            @(posedge restart);
            reset = 1'b0;
            repeat (3) @(posedge clk5);
            #0.5;
            reset = 1'b1;
        end
    end

endmodule

`default_nettype wire
